//--- cpu_pkg.sv
package cpu_pkg;

    // data and instruction word size
    localparam int word_width = 16;

    // address field of an instruction
    localparam int addr_width = 12;

    // words in program memory and in data memory
    localparam int mem_depth = 4096;

    // instruction layout
    //   [15:12] opcode
    //   [11:0]  memory address
    // alu works on acc and the word at that address
    typedef enum logic [3:0] {
        // memory
        op_load,
        op_store,
        // arithmetic, mul keeps low 16 bits
        op_add,
        op_sub,
        op_mul,
        // bitwise
        op_and,
        op_or,
        op_xor,
        // single-bit moves of acc, memory word not used
        op_shl,
        op_shr,
        op_rol,
        // compares give 1 or 0, gt is unsigned
        op_gt,
        op_eq,
        // control
        op_jmp,
        op_jz,
        op_halt
    } opcode_e;

endpackage

//--- word_ram.sv
`timescale 1ns/100ps

module word_ram (
    input  logic                          clock,
    input  logic                          write,
    input  logic [cpu_pkg::addr_width-1:0] write_addr,
    input  logic [cpu_pkg::word_width-1:0] write_data,
    input  logic [cpu_pkg::addr_width-1:0] read_addr,
    output logic [cpu_pkg::word_width-1:0] read_data
);
    import cpu_pkg::*;

    // storage, contents undefined until written
    logic [word_width-1:0] mem [mem_depth];

    // one write port
    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read, old word on same-address write
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          halted,
    input  logic                          redirect,
    input  logic [cpu_pkg::addr_width-1:0] redirect_target,
    input  logic                          prog_write,
    input  logic [cpu_pkg::addr_width-1:0] prog_addr,
    input  logic [cpu_pkg::word_width-1:0] prog_data,
    output logic                          fetch_valid,
    output logic [cpu_pkg::word_width-1:0] fetch_instr
);
    import cpu_pkg::*;

    // program counter
    logic [addr_width-1:0] pc;

    // one instruction per clock while running
    logic issue;

    assign issue = run && !halted;

    // program memory
    // host loads it while run is low
    // read address always follows pc, valid tells if it counts
    word_ram i_prog_ram (
        .clock      (clock),
        .write      (prog_write),
        .write_addr (prog_addr),
        .write_data (prog_data),
        .read_addr  (pc),
        .read_data  (fetch_instr)
    );

    // valid lags the issue by one cycle, like the ram read
    // a redirect kills the word read on the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= issue && !redirect;
        end
    end

    // pc update
    // redirect wins over the increment
    // 12-bit add wraps 4095 back to 0
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (issue) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

//--- operand_stage.sv
`timescale 1ns/100ps

module operand_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          redirect,
    input  logic                          fetch_valid,
    input  logic [cpu_pkg::word_width-1:0] fetch_instr,
    input  logic                          data_write,
    input  logic [cpu_pkg::addr_width-1:0] data_addr,
    input  logic [cpu_pkg::word_width-1:0] data_wdata,
    input  logic                          store_write,
    input  logic [cpu_pkg::addr_width-1:0] store_addr,
    input  logic [cpu_pkg::word_width-1:0] store_data,
    output logic                          oper_valid,
    output logic [cpu_pkg::word_width-1:0] oper_instr,
    output logic [cpu_pkg::word_width-1:0] oper_data
);
    import cpu_pkg::*;

    // shared write port of the data memory
    logic                  ram_write;
    logic [addr_width-1:0] ram_write_addr;
    logic [word_width-1:0] ram_write_data;

    // host has priority, it only writes while run is low
    assign ram_write      = data_write || store_write;
    assign ram_write_addr = data_write ? data_addr : store_addr;
    assign ram_write_data = data_write ? data_wdata : store_data;

    // data memory
    // read at the address field of the fetched word
    // a store retiring on the same edge is not seen here
    word_ram i_data_ram (
        .clock      (clock),
        .write      (ram_write),
        .write_addr (ram_write_addr),
        .write_data (ram_write_data),
        .read_addr  (fetch_instr[addr_width-1:0]),
        .read_data  (oper_data)
    );

    // instruction travels with its memory word
    always_ff @(posedge clock) begin
        oper_instr <= fetch_instr;
    end

    // squash on redirect
    always_ff @(posedge clock) begin
        if (reset) begin
            oper_valid <= 1'b0;
        end else begin
            oper_valid <= fetch_valid && !redirect;
        end
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          oper_valid,
    input  logic [cpu_pkg::word_width-1:0] oper_instr,
    input  logic [cpu_pkg::word_width-1:0] oper_data,
    output logic [cpu_pkg::word_width-1:0] acc,
    output logic                          halted,
    output logic                          redirect,
    output logic [cpu_pkg::addr_width-1:0] redirect_target,
    output logic                          store_write,
    output logic [cpu_pkg::addr_width-1:0] store_addr,
    output logic [cpu_pkg::word_width-1:0] store_data
);
    import cpu_pkg::*;

    // decoded fields
    opcode_e               op;
    logic [addr_width-1:0] addr;

    // instruction counts only when valid and not halted
    logic active;

    // store retired on the previous cycle
    logic                  prev_store;
    logic [addr_width-1:0] prev_store_addr;

    // operand select and alu
    logic                  forward;
    logic [word_width-1:0] operand;
    logic [word_width-1:0] alu_result;
    logic                  acc_write;
    logic                  taken;

    assign op     = opcode_e'(oper_instr[word_width-1:addr_width]);
    assign addr   = oper_instr[addr_width-1:0];
    assign active = oper_valid && !halted;

    // the word right after a store was read before the store landed
    // acc still holds the stored value, so use it
    assign forward = prev_store && (prev_store_addr == addr);
    assign operand = forward ? acc : oper_data;

    always_comb begin
        case (op)
            op_load: alu_result = operand;
            op_add:  alu_result = acc + operand;
            op_sub:  alu_result = acc - operand;
            op_mul:  alu_result = acc * operand;
            op_and:  alu_result = acc & operand;
            op_or:   alu_result = acc | operand;
            op_xor:  alu_result = acc ^ operand;
            // shifts by one, memory word unused
            op_shl:  alu_result = {acc[word_width-2:0], 1'b0};
            op_shr:  alu_result = {1'b0, acc[word_width-1:1]};
            op_rol:  alu_result = {acc[word_width-2:0], acc[word_width-1]};
            op_gt:   alu_result = {{(word_width-1){1'b0}}, acc > operand};
            op_eq:   alu_result = {{(word_width-1){1'b0}}, acc == operand};
            // store and control leave acc alone
            default: alu_result = acc;
        endcase
    end

    // everything but store and control writes acc
    assign acc_write = active && (op inside {op_load, op_add, op_sub, op_mul,
                                             op_and, op_or, op_xor, op_shl,
                                             op_shr, op_rol, op_gt, op_eq});

    // jz tests acc as it is before this instruction
    assign taken = (op == op_jmp) || (op == op_jz && acc == '0);

    // halt redirects too, so the two younger words are dropped
    assign redirect        = active && (taken || op == op_halt);
    assign redirect_target = addr;

    // store drives the data memory write port
    assign store_write = active && (op == op_store);
    assign store_addr  = addr;
    assign store_data  = acc;

    always_ff @(posedge clock) begin
        if (reset) begin
            acc <= '0;
        end else if (acc_write) begin
            acc <= alu_result;
        end
    end

    // sticky until reset
    always_ff @(posedge clock) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (active && op == op_halt) begin
            halted <= 1'b1;
        end
    end

    // remember last cycle's store for the forwarding check
    always_ff @(posedge clock) begin
        if (reset) begin
            prev_store <= 1'b0;
        end else begin
            prev_store <= store_write;
        end
    end

    always_ff @(posedge clock) begin
        prev_store_addr <= store_addr;
    end

endmodule

//--- acc_cpu.sv
`timescale 1ns/100ps

module acc_cpu (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          prog_write,
    input  logic [cpu_pkg::addr_width-1:0] prog_addr,
    input  logic [cpu_pkg::word_width-1:0] prog_data,
    input  logic                          data_write,
    input  logic [cpu_pkg::addr_width-1:0] data_addr,
    input  logic [cpu_pkg::word_width-1:0] data_wdata,
    output logic [cpu_pkg::word_width-1:0] acc,
    output logic                          halted
);
    import cpu_pkg::*;

    // fetch to operand
    logic                  fetch_valid;
    logic [word_width-1:0] fetch_instr;

    // operand to execute
    logic                  oper_valid;
    logic [word_width-1:0] oper_instr;
    logic [word_width-1:0] oper_data;

    // execute back to the front
    logic                  redirect;
    logic [addr_width-1:0] redirect_target;
    logic                  store_write;
    logic [addr_width-1:0] store_addr;
    logic [word_width-1:0] store_data;

    fetch_stage i_fetch (
        .clock           (clock),
        .reset           (reset),
        .run             (run),
        .halted          (halted),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .prog_write      (prog_write),
        .prog_addr       (prog_addr),
        .prog_data       (prog_data),
        .fetch_valid     (fetch_valid),
        .fetch_instr     (fetch_instr)
    );

    operand_stage i_operand (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .store_write (store_write),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .oper_valid  (oper_valid),
        .oper_instr  (oper_instr),
        .oper_data   (oper_data)
    );

    execute_stage i_execute (
        .clock           (clock),
        .reset           (reset),
        .oper_valid      (oper_valid),
        .oper_instr      (oper_instr),
        .oper_data       (oper_data),
        .acc             (acc),
        .halted          (halted),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .store_write     (store_write),
        .store_addr      (store_addr),
        .store_data      (store_data)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clock,
    output logic reset
);
    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // power-on reset for ten rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

//--- tb_acc_cpu.sv
`timescale 1ns/100ps

module tb_acc_cpu;
    import cpu_pkg::*;

    // five tests, 2000 cycles each
    localparam int num_tests = 5;
    localparam int cycle_ns  = 10;

    logic                  clock;
    logic                  por_reset;
    logic                  test_reset;
    logic                  reset;
    logic                  run;
    logic                  prog_write;
    logic [addr_width-1:0] prog_addr;
    logic [word_width-1:0] prog_data;
    logic                  data_write;
    logic [addr_width-1:0] data_addr;
    logic [word_width-1:0] data_wdata;
    logic [word_width-1:0] acc;
    logic                  halted;

    // program being built, and the reference copies of both memories
    logic [word_width-1:0] prog_q[$];
    logic [word_width-1:0] prog_image [mem_depth];
    logic [word_width-1:0] model_data [mem_depth];

    // model result of the most recent program
    logic [word_width-1:0] last_expected;

    int check_errors = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    assign reset = por_reset || test_reset;

    tb_clock i_clock (
        .clock (clock),
        .reset (por_reset)
    );

    acc_cpu i_dut (
        .clock      (clock),
        .reset      (reset),
        .run        (run),
        .prog_write (prog_write),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .acc        (acc),
        .halted     (halted)
    );

    // opcode on top, address below
    function automatic void emit(opcode_e op, int addr);
        prog_q.push_back({op, addr_width'(addr)});
    endfunction

    // host data write, run held low meanwhile
    task automatic put_data(int addr, int value);
        @(posedge clock);
        #1;
        run        = 1'b0;
        data_write = 1'b1;
        data_addr  = addr_width'(addr);
        data_wdata = word_width'(value);
        model_data[addr] = word_width'(value);
        @(posedge clock);
        #1;
        data_write = 1'b0;
    endtask

    // program queue goes to address 0 upward
    task automatic load_program();
        int i;
        for (i = 0; i < prog_q.size(); i++) begin
            @(posedge clock);
            #1;
            run        = 1'b0;
            prog_write = 1'b1;
            prog_addr  = addr_width'(i);
            prog_data  = prog_q[i];
            prog_image[i] = prog_q[i];
        end
        @(posedge clock);
        #1;
        prog_write = 1'b0;
    endtask

    task automatic pulse_reset();
        @(posedge clock);
        #1;
        run        = 1'b0;
        test_reset = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        test_reset = 1'b0;
    endtask

    // reference model, one instruction per step, no pipeline
    function automatic logic [word_width-1:0] model_run();
        logic [word_width-1:0] a;
        logic [word_width-1:0] w;
        logic [word_width-1:0] ins;
        logic [addr_width-1:0] pc;
        logic [addr_width-1:0] ad;
        opcode_e               op;
        bit                    done;
        int                    steps;
        a     = '0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 10000) begin
            ins = prog_image[pc];
            op  = opcode_e'(ins[word_width-1:addr_width]);
            ad  = ins[addr_width-1:0];
            w   = model_data[ad];
            pc  = pc + 1'b1;
            steps++;
            case (op)
                op_load:  a = w;
                op_store: model_data[ad] = a;
                op_add:   a = a + w;
                op_sub:   a = a - w;
                op_mul:   a = a * w;
                op_and:   a = a & w;
                op_or:    a = a | w;
                op_xor:   a = a ^ w;
                op_shl:   a = a << 1;
                op_shr:   a = a >> 1;
                op_rol:   a = {a[word_width-2:0], a[word_width-1]};
                op_gt:    a = (a > w) ? word_width'(1) : '0;
                op_eq:    a = (a == w) ? word_width'(1) : '0;
                op_jmp:   pc = ad;
                op_jz:    pc = (a == '0) ? ad : pc;
                default:  done = 1'b1;
            endcase
        end
        return a;
    endfunction

    task automatic compare_word(string name, logic [word_width-1:0] got,
                                logic [word_width-1:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
            check_errors++;
        end
    endtask

    task automatic compare_bit(string name, logic got, logic expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, expected);
            check_errors++;
        end
    endtask

    // pause_after > 0 drops run for 8 cycles that many cycles in
    task automatic run_and_check(int pause_after);
        logic [word_width-1:0] expected;
        pulse_reset();
        load_program();
        expected      = model_run();
        last_expected = expected;
        @(posedge clock);
        #1;
        run = 1'b1;
        if (pause_after > 0) begin
            repeat (pause_after) @(posedge clock);
            #1;
            run = 1'b0;
            repeat (8) @(posedge clock);
            #1;
            run = 1'b1;
        end
        // poll halted once per clock
        while (!halted) begin
            @(posedge clock);
            #1;
        end
        // one clock later halted must still be set
        @(posedge clock);
        #1;
        compare_word("acc", acc, expected);
        compare_bit("halted", halted, 1'b1);
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (check_errors == errors_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, check_errors - errors_before);
        end
    endtask

    task automatic test_alu();
        int errors_before;
        errors_before = check_errors;
        put_data(100, 'h1234);
        put_data(101, 'h0f0f);
        put_data(102, 'h0321);
        put_data(103, 'h0007);
        put_data(104, 'hff3c);
        put_data(105, 'h8001);
        put_data(106, 'h5555);
        put_data(107, 'h0001);
        prog_q = {};
        emit(op_load, 100);
        emit(op_add, 101);
        emit(op_sub, 102);
        emit(op_mul, 103);
        emit(op_and, 104);
        emit(op_or, 105);
        emit(op_xor, 106);
        emit(op_halt, 0);
        run_and_check(0);
        // 8001 > 7 only when unsigned, then 1 == 1
        prog_q = {};
        emit(op_load, 105);
        emit(op_gt, 103);
        emit(op_eq, 107);
        emit(op_halt, 0);
        run_and_check(0);
        report_test("alu", errors_before);
    endtask

    task automatic test_shifts();
        int      errors_before;
        opcode_e shift_ops [3];
        errors_before = check_errors;
        shift_ops = '{op_shl, op_shr, op_rol};
        // both end bits set, the addressed word must not matter
        put_data(200, 'h8001);
        put_data(201, 'h7777);
        foreach (shift_ops[k]) begin
            prog_q = {};
            emit(op_load, 200);
            emit(shift_ops[k], 201);
            emit(op_halt, 0);
            run_and_check(0);
        end
        report_test("shifts", errors_before);
    endtask

    task automatic test_store_load();
        int errors_before;
        errors_before = check_errors;
        put_data(300, 'h5a5a);
        put_data(301, 'h0001);
        put_data(302, 'hdead);
        put_data(303, 'hbeef);
        // load right behind the store, forwarding path
        prog_q = {};
        emit(op_load, 300);
        emit(op_add, 301);
        emit(op_store, 302);
        emit(op_load, 302);
        emit(op_halt, 0);
        run_and_check(0);
        // two unrelated words in between, memory path
        prog_q = {};
        emit(op_load, 300);
        emit(op_store, 303);
        emit(op_load, 301);
        emit(op_add, 301);
        emit(op_load, 303);
        emit(op_halt, 0);
        run_and_check(0);
        report_test("store_load", errors_before);
    endtask

    // counts down from 5, adding 3 to a tally each pass
    task automatic build_countdown();
        put_data(400, 5);
        put_data(401, 1);
        put_data(402, 0);
        put_data(403, 0);
        put_data(404, 3);
        prog_q = {};
        emit(op_load, 400);
        emit(op_jz, 9);
        emit(op_sub, 401);
        emit(op_store, 402);
        emit(op_load, 403);
        emit(op_add, 404);
        emit(op_store, 403);
        emit(op_load, 402);
        emit(op_jmp, 1);
        emit(op_load, 403);
        emit(op_halt, 0);
    endtask

    task automatic test_branches();
        int errors_before;
        errors_before = check_errors;
        build_countdown();
        run_and_check(0);
        // words after the jmp and after the halt are squashed
        put_data(500, 7);
        put_data(501, 1);
        put_data(502, 9);
        prog_q = {};
        emit(op_load, 500);
        emit(op_jmp, 4);
        emit(op_add, 501);
        emit(op_add, 501);
        emit(op_add, 501);
        emit(op_halt, 0);
        emit(op_mul, 502);
        emit(op_add, 501);
        run_and_check(0);
        report_test("branches", errors_before);
    endtask

    task automatic test_halt_run();
        int errors_before;
        errors_before = check_errors;
        // run drops mid-loop, result must not change
        build_countdown();
        run_and_check(12);
        // stays halted with run still high
        repeat (50) begin
            @(posedge clock);
            #1;
            compare_word("acc", acc, last_expected);
            compare_bit("halted", halted, 1'b1);
        end
        pulse_reset();
        compare_word("acc", acc, '0);
        compare_bit("halted", halted, 1'b0);
        report_test("halt_run", errors_before);
    endtask

    initial begin
        #(num_tests * 2000 * cycle_ns);
        $display("watchdog: run did not finish within %0d cycles", num_tests * 2000);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        test_reset = 1'b0;
        run        = 1'b0;
        prog_write = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        data_write = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        @(negedge por_reset);
        test_alu();
        test_shifts();
        test_store_load();
        test_branches();
        test_halt_run();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, check_errors);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- acc_cpu.f
cpu_pkg.sv
word_ram.sv
fetch_stage.sv
operand_stage.sv
execute_stage.sv
acc_cpu.sv
tb_clock.sv
tb_acc_cpu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the acc_cpu testbench with verilator
# a failure line anywhere in the log fails the run
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_acc_cpu -f acc_cpu.f \
    -o sim_acc_cpu > build.log 2>&1 &&
./obj_dir/sim_acc_cpu > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
exit 0
